// ==== logic/backendPkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, instruction field positions and types
// for the in-order integer back end
////////////////////////////////////////////////////////////
`default_nettype none

package backendPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    localparam int DATA_W     = 32;                 // Datapath width
    localparam int REG_CNT    = 16;                 // Architectural registers
    localparam int REG_W      = $clog2(REG_CNT);    // Register index width
    localparam int IMM_W      = 15;                 // Raw immediate width
    localparam int SHAMT_W    = 5;                  // Shift amount bits from operand B
    localparam int PIPE_DEPTH = 4;                  // Decode, operand, execute, retire

    ////////////////////////////////////////////////////////////
    // Instruction word layout
    localparam int OP_MSB      = 31;
    localparam int OP_LSB      = 28;
    localparam int RD_MSB      = 27;
    localparam int RD_LSB      = 24;
    localparam int RS1_MSB     = 23;
    localparam int RS1_LSB     = 20;
    localparam int RS2_MSB     = 19;
    localparam int RS2_LSB     = 16;
    localparam int IMM_SEL_BIT = 15;                // 1 => immediate replaces rs2
    localparam int IMM_MSB     = 14;
    localparam int IMM_LSB     = 0;                 // Sign extended from IMM_MSB

    // Data types
    typedef logic [DATA_W-1:0] dataT;
    typedef logic [31:0]       pcT;
    typedef logic [REG_W-1:0]  regIdxT;
    typedef logic [IMM_W-1:0]  immT;
    typedef logic [31:0]       instrT;

    // ALU opcodes, 8 to 15 are illegal
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SRA = 4'd7                               // Highest legal opcode
    } aluOpT;

endpackage

`default_nettype wire

// ==== logic/stageIfs.sv ====
////////////////////////////////////////////////////////////
// Stage to stage interfaces: decoded uop, issued uop,
// result / bypass bus and register file read port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

// Decode to operand fetch
interface uopIf import backendPkg::*; ();
    logic   valid;      // Single cycle strobe
    pcT     pc;
    aluOpT  op;
    logic   illegal;    // Opcode 8 to 15
    regIdxT rd;         // Zero when illegal
    regIdxT rs1;
    regIdxT rs2;
    logic   useImm;
    dataT   imm;        // Already sign extended

    modport src (output valid, pc, op, illegal, rd, rs1, rs2, useImm, imm);
    modport dst (input  valid, pc, op, illegal, rd, rs1, rs2, useImm, imm);
endinterface

// Operand fetch to execute
interface issueIf import backendPkg::*; ();
    logic   valid;
    pcT     pc;
    aluOpT  op;
    logic   illegal;
    regIdxT rd;
    dataT   srcA;       // Bypassed operand A
    dataT   srcB;       // Bypassed operand B or immediate

    modport src (output valid, pc, op, illegal, rd, srcA, srcB);
    modport dst (input  valid, pc, op, illegal, rd, srcA, srcB);
endinterface

// Result of a stage, also a bypass source for operand fetch
interface resultIf import backendPkg::*; ();
    logic   valid;
    pcT     pc;
    regIdxT rd;
    logic   illegal;
    dataT   data;

    modport src    (output valid, pc, rd, illegal, data);
    modport dst    (input  valid, pc, rd, illegal, data);
    modport bypass (input  valid, rd, illegal, data);   // No pc needed for forwarding
endinterface

// Register file read, two ports, combinational
interface regReadIf import backendPkg::*; ();
    regIdxT rs1;
    regIdxT rs2;
    dataT   rdata1;
    dataT   rdata2;

    modport req (output rs1, rs2, input  rdata1, rdata2);
    modport rsp (input  rs1, rs2, output rdata1, rdata2);
endinterface

`default_nettype wire

// ==== logic/decodeStage.sv ====
////////////////////////////////////////////////////////////
// Decode stage: instruction register and field split
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decodeStage import backendPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  exFlush,
    input  logic  instrValid,
    input  instrT instrWord,
    input  pcT    instrPc,
    uopIf.src     uop
);

    logic                   decValid;   // Decode register occupied
    instrT                  decWord;
    pcT                     decPc;
    logic [OP_MSB-OP_LSB:0] rawOp;
    immT                    rawImm;
    logic                   isIllegal;

    // Valid bit, flush drops the incoming strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= instrValid && !exFlush;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            decWord <= instrWord;   // Payload only, no reset
            decPc   <= instrPc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Field split
    assign rawOp     = decWord[OP_MSB:OP_LSB];
    assign rawImm    = decWord[IMM_MSB:IMM_LSB];
    assign isIllegal = (rawOp > OP_SRA);

    assign uop.valid   = decValid;
    assign uop.pc      = decPc;
    assign uop.op      = isIllegal ? OP_ADD : aluOpT'(rawOp);  // Keep enum in range
    assign uop.illegal = isIllegal;
    assign uop.rd      = isIllegal ? '0 : decWord[RD_MSB:RD_LSB]; // No writeback, no bypass
    assign uop.rs1     = decWord[RS1_MSB:RS1_LSB];
    assign uop.rs2     = decWord[RS2_MSB:RS2_LSB];
    assign uop.useImm  = decWord[IMM_SEL_BIT];
    assign uop.imm     = {{(DATA_W-IMM_W){rawImm[IMM_W-1]}}, rawImm};

    // Illegal strobe shows up next cycle flagged and with rd cleared
    illegalRdCleared: assert property (@(posedge clk) disable iff (!rstN)
        instrValid && !exFlush && (instrWord[OP_MSB:OP_LSB] > OP_SRA)
        |=> uop.valid && uop.illegal && (uop.rd == '0))
        else $error("illegal uop kept a destination register");

endmodule

`default_nettype wire

// ==== logic/operandStage.sv ====
////////////////////////////////////////////////////////////
// Operand fetch: register file read, bypass select and
// the issue register feeding execute
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operandStage import backendPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     exFlush,
    uopIf.dst        uop,
    resultIf.bypass  aluNow,     // Distance 1, combinational ALU output
    resultIf.bypass  executed,   // Distance 2
    resultIf.bypass  retiring,   // Distance 3, register file not yet written
    regReadIf.req    regRd,
    issueIf.src      issue
);

    dataT   opA;
    dataT   opB;        // Before immediate select
    logic   issValid;
    pcT     issPc;
    aluOpT  issOp;
    logic   issIllegal;
    regIdxT issRd;
    dataT   issSrcA;
    dataT   issSrcB;

    // A producer matches only when valid, legal and writing a real register
    function automatic logic bypassHit(logic v, logic ill, regIdxT prodRd, regIdxT src);
        return v && !ill && (prodRd != '0) && (prodRd == src);
    endfunction

    // Newest producer wins, register 0 is hardwired
    function automatic dataT pickOperand(regIdxT src, dataT rfData);
        dataT sel;
        if (src == '0) begin
            sel = '0;
        end else if (bypassHit(aluNow.valid, aluNow.illegal, aluNow.rd, src)) begin
            sel = aluNow.data;
        end else if (bypassHit(executed.valid, executed.illegal, executed.rd, src)) begin
            sel = executed.data;
        end else if (bypassHit(retiring.valid, retiring.illegal, retiring.rd, src)) begin
            sel = retiring.data;
        end else begin
            sel = rfData;
        end
        return sel;
    endfunction

    assign regRd.rs1 = uop.rs1;
    assign regRd.rs2 = uop.rs2;

    always_comb begin
        opA = pickOperand(uop.rs1, regRd.rdata1);
        opB = pickOperand(uop.rs2, regRd.rdata2);
    end

    ////////////////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issValid <= 1'b0;
        end else begin
            issValid <= uop.valid && !exFlush;
        end
    end

    always_ff @(posedge clk) begin
        if (uop.valid) begin
            issPc      <= uop.pc;
            issOp      <= uop.op;
            issIllegal <= uop.illegal;
            issRd      <= uop.rd;
            issSrcA    <= opA;
            issSrcB    <= uop.useImm ? uop.imm : opB;   // Immediate form
        end
    end

    assign issue.valid   = issValid;
    assign issue.pc      = issPc;
    assign issue.op      = issOp;
    assign issue.illegal = issIllegal;
    assign issue.rd      = issRd;
    assign issue.srcA    = issSrcA;
    assign issue.srcB    = issSrcB;

    // Register file and every bypass must deliver known data
    operandsKnown: assert property (@(posedge clk) disable iff (!rstN)
        issue.valid |-> !$isunknown({issue.srcA, issue.srcB}))
        else $error("unknown operand issued to execute");

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
////////////////////////////////////////////////////////////
// Execute stage: integer ALU and execute result register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module executeStage import backendPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  exFlush,
    issueIf.dst   issue,
    resultIf.src  aluNow,
    resultIf.src  executed
);

    logic [SHAMT_W-1:0] shamt;
    dataT               aluResult;
    logic               exValid;
    pcT                 exPc;
    regIdxT             exRd;
    logic               exIllegal;
    dataT               exData;

    assign shamt = issue.srcB[SHAMT_W-1:0];     // Low bits only

    ////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (issue.op)
            OP_ADD:  aluResult = issue.srcA + issue.srcB;
            OP_SUB:  aluResult = issue.srcA - issue.srcB;
            OP_AND:  aluResult = issue.srcA & issue.srcB;
            OP_OR:   aluResult = issue.srcA | issue.srcB;
            OP_XOR:  aluResult = issue.srcA ^ issue.srcB;
            OP_SLL:  aluResult = issue.srcA << shamt;
            OP_SRL:  aluResult = issue.srcA >> shamt;
            OP_SRA:  aluResult = dataT'($signed(issue.srcA) >>> shamt);  // Arithmetic
            default: aluResult = '0;
        endcase
        if (issue.illegal) begin
            aluResult = '0;     // Illegal retires with zero data
        end
    end

    // Same-cycle result, youngest bypass source
    assign aluNow.valid   = issue.valid;
    assign aluNow.pc      = issue.pc;
    assign aluNow.rd      = issue.rd;
    assign aluNow.illegal = issue.illegal;
    assign aluNow.data    = aluResult;

    // Result register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= issue.valid && !exFlush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            exPc      <= issue.pc;
            exRd      <= issue.rd;
            exIllegal <= issue.illegal;
            exData    <= aluResult;
        end
    end

    assign executed.valid   = exValid;
    assign executed.pc      = exPc;
    assign executed.rd      = exRd;
    assign executed.illegal = exIllegal;
    assign executed.data    = exData;

endmodule

`default_nettype wire

// ==== logic/retireStage.sv ====
////////////////////////////////////////////////////////////
// Retire stage: retire register, architectural register
// file with two read ports, retire outputs
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module retireStage import backendPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   exFlush,
    resultIf.dst   executed,
    regReadIf.rsp  regRd,
    resultIf.src   retiring,
    output logic   retireValid,
    output pcT     retirePc,
    output regIdxT retireRd,
    output dataT   retireData,
    output logic   retireIllegal
);

    logic   retValid;
    pcT     retPc;
    regIdxT retRd;
    logic   retIllegal;
    dataT   retData;
    dataT   regFile [REG_CNT];
    logic   wrEn;

    // Retire register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retValid <= 1'b0;
        end else begin
            retValid <= executed.valid && !exFlush;
        end
    end

    always_ff @(posedge clk) begin
        if (executed.valid) begin
            retPc      <= executed.pc;
            retRd      <= executed.rd;
            retIllegal <= executed.illegal;
            retData    <= executed.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Register file, written at the end of the retire cycle
    assign wrEn = retValid && !retIllegal && (retRd != '0);   // Flush does not block it

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regFile <= '{default: '0};      // Architectural state starts at zero
        end else if (wrEn) begin
            regFile[retRd] <= retData;
        end
    end

    // Reads see the old value during a write, retiring bypass covers it
    assign regRd.rdata1 = regFile[regRd.rs1];
    assign regRd.rdata2 = regFile[regRd.rs2];

    assign retiring.valid   = retValid;
    assign retiring.pc      = retPc;
    assign retiring.rd      = retRd;
    assign retiring.illegal = retIllegal;
    assign retiring.data    = retData;

    assign retireValid   = retValid;
    assign retirePc      = retPc;
    assign retireRd      = retRd;
    assign retireData    = retData;
    assign retireIllegal = retIllegal;

    zeroRegFixed: assert property (@(posedge clk) disable iff (!rstN)
        regFile[0] == '0)
        else $error("register 0 was written");

endmodule

`default_nettype wire

// ==== logic/backendTop.sv ====
////////////////////////////////////////////////////////////
// Back end top: stage chain, shared flush, busy flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backendTop import backendPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   exFlush,        // Kills everything not yet at retire
    input  logic   instrValid,     // Single cycle strobe, never back-pressured
    input  instrT  instrWord,
    input  pcT     instrPc,
    output logic   retireValid,
    output pcT     retirePc,
    output regIdxT retireRd,
    output dataT   retireData,
    output logic   retireIllegal,
    output logic   pipelineBusy    // Any stage register occupied
);

    ////////////////////////////////////////////////////////////
    // Stage interconnect
    uopIf     uopBus ();            // Decode -> operand fetch
    issueIf   issueBus ();          // Operand fetch -> execute
    resultIf  aluNow ();            // Execute combinational result
    resultIf  executed ();          // Execute register
    resultIf  retiring ();          // Retire register
    regReadIf regRd ();             // Operand fetch <-> register file

    logic [PIPE_DEPTH-1:0] stageValid;

    decodeStage uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .exFlush    (exFlush),
        .instrValid (instrValid),
        .instrWord  (instrWord),
        .instrPc    (instrPc),
        .uop        (uopBus)
    );

    operandStage uOperand (
        .clk      (clk),
        .rstN     (rstN),
        .exFlush  (exFlush),
        .uop      (uopBus),
        .aluNow   (aluNow),
        .executed (executed),
        .retiring (retiring),
        .regRd    (regRd),
        .issue    (issueBus)
    );

    executeStage uExecute (
        .clk      (clk),
        .rstN     (rstN),
        .exFlush  (exFlush),
        .issue    (issueBus),
        .aluNow   (aluNow),
        .executed (executed)
    );

    retireStage uRetire (
        .clk           (clk),
        .rstN          (rstN),
        .exFlush       (exFlush),
        .executed      (executed),
        .regRd         (regRd),
        .retiring      (retiring),
        .retireValid   (retireValid),
        .retirePc      (retirePc),
        .retireRd      (retireRd),
        .retireData    (retireData),
        .retireIllegal (retireIllegal)
    );

    // Oldest stage in the top bit
    assign stageValid   = {retiring.valid, executed.valid, issueBus.valid, uopBus.valid};
    assign pipelineBusy = |stageValid;

endmodule

`default_nettype wire

// ==== verif/backendModel.svh ====
////////////////////////////////////////////////////////////
// Reference ALU function, architectural register copy
// and the queue of expected retires
////////////////////////////////////////////////////////////
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// One expected retire, in program order
typedef struct {
    pcT     pc;
    regIdxT rd;             // Zero for illegal opcodes
    dataT   data;
    logic   illegal;
    int     retireCycle;    // Strobe cycle plus pipeline depth
} expectT;

dataT   modelRegs [REG_CNT];    // Architectural state as the ISA sees it
expectT expQ [$];

// ISA result of one instruction, illegal opcodes give zero
function automatic dataT computeResult(input logic [3:0] op, input dataT a, input dataT b,
                                       input logic useImm, input immT imm);
    dataT opB;
    dataT res;
    int   sh;
    opB = useImm ? dataT'($signed(imm)) : b;     // Sign extended immediate
    sh  = opB[SHAMT_W-1:0];
    case (op)
        4'd0:    res = a + opB;
        4'd1:    res = a - opB;
        4'd2:    res = a & opB;
        4'd3:    res = a | opB;
        4'd4:    res = a ^ opB;
        4'd5:    res = a << sh;
        4'd6:    res = a >> sh;
        4'd7: begin
            res = a >> sh;
            if (a[DATA_W-1]) begin
                res = res | ~({DATA_W{1'b1}} >> sh);   // Fill with the sign bit
            end
        end
        default: res = '0;
    endcase
    return res;
endfunction

function automatic void clearModel();
    foreach (modelRegs[i]) begin
        modelRegs[i] = '0;
    end
    expQ.delete();
endfunction

// Executes one surviving instruction and queues its retire
task automatic commitInstr(input instrT word, input pcT pc, input int strobeCycle);
    logic [3:0] op;
    regIdxT     rd;
    expectT     want;
    op               = word[OP_MSB:OP_LSB];
    rd               = word[RD_MSB:RD_LSB];
    want.illegal     = (op >= 4'd8);
    want.rd          = want.illegal ? regIdxT'(0) : rd;
    want.data        = computeResult(op, modelRegs[word[RS1_MSB:RS1_LSB]],
                                     modelRegs[word[RS2_MSB:RS2_LSB]],
                                     word[IMM_SEL_BIT], word[IMM_MSB:IMM_LSB]);
    want.pc          = pc;
    want.retireCycle = strobeCycle + PIPE_DEPTH;
    if (!want.illegal && (rd != 0)) begin
        modelRegs[rd] = want.data;          // Register 0 stays zero
    end
    expQ.push_back(want);
endtask

`endif

// ==== verif/backendTb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the back end: clock, reset, stimulus,
// flush window tracking, retire compare and reports
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backendTb import backendPkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 5;
    localparam int BUSY_STROBES   = 4;
    localparam int RAND_STROBES   = 24;
    localparam int CHAIN_LEN      = 8;                  // Per dependency distance
    localparam int ZERO_GROUPS    = 4;
    localparam int FLUSH_STROBES  = 20;
    localparam int TOTAL_STROBES  = BUSY_STROBES + RAND_STROBES + 4 * CHAIN_LEN
                                  + 5 * ZERO_GROUPS + FLUSH_STROBES;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_STROBES + PIPE_DEPTH * NUM_TESTS + RESET_CYCLES;

    logic   clk;
    logic   rstN;
    logic   exFlush;
    logic   instrValid;
    instrT  instrWord;
    pcT     instrPc;
    logic   retireValid;
    pcT     retirePc;
    regIdxT retireRd;
    dataT   retireData;
    logic   retireIllegal;
    logic   pipelineBusy;

    // Strobed instruction still inside the flush window
    typedef struct {
        instrT word;
        pcT    pc;
        int    strobe;
    } pendingT;

    pendingT inFlight [$];
    integer  seed = 15;
    int      cycle;
    int      errorCount;
    int      retiredCount;
    int      testsDone;
    int      testErrorBase;
    int      testRetireBase;
    string   testName;
    pcT      nextPc;

    `include "backendModel.svh"

    backendTop dut (
        .clk           (clk),
        .rstN          (rstN),
        .exFlush       (exFlush),
        .instrValid    (instrValid),
        .instrWord     (instrWord),
        .instrPc       (instrPc),
        .retireValid   (retireValid),
        .retirePc      (retirePc),
        .retireRd      (retireRd),
        .retireData    (retireData),
        .retireIllegal (retireIllegal),
        .pipelineBusy  (pipelineBusy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    function automatic int randomBits(input int width);
        return $random(seed) & ((1 << width) - 1);
    endfunction

    function automatic instrT encodeInstr(input logic [3:0] op, input regIdxT rd,
                                          input regIdxT rs1, input regIdxT rs2,
                                          input logic useImm, input immT imm);
        instrT w;
        w                  = '0;
        w[OP_MSB:OP_LSB]   = op;
        w[RD_MSB:RD_LSB]   = rd;
        w[RS1_MSB:RS1_LSB] = rs1;
        w[RS2_MSB:RS2_LSB] = rs2;
        w[IMM_SEL_BIT]     = useImm;
        w[IMM_MSB:IMM_LSB] = imm;
        return w;
    endfunction

    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h, actual %h", testName, field, expected, actual);
            errorCount++;
        end
    endtask

    // One clock of stimulus, commits instructions past the flush window
    task automatic stepCycle(input logic strobe, input instrT word, input logic flush);
        pendingT entry;
        @(posedge clk);
        instrValid <= strobe;
        instrWord  <= word;
        instrPc    <= nextPc;
        exFlush    <= flush;
        cycle++;
        while (inFlight.size() > 0 && inFlight[0].strobe + PIPE_DEPTH <= cycle) begin
            entry = inFlight.pop_front();
            commitInstr(entry.word, entry.pc, entry.strobe);
        end
        if (strobe) begin
            entry.word   = word;
            entry.pc     = nextPc;
            entry.strobe = cycle;
            inFlight.push_back(entry);
            nextPc += 4;
        end
        if (flush) begin
            inFlight.delete();      // Strobes of the last PIPE_DEPTH cycles die
        end
    endtask

    task automatic idleCycle();
        stepCycle(1'b0, '0, 1'b0);
    endtask

    task automatic startTest(input string name);
        testName       = name;
        testErrorBase  = errorCount;
        testRetireBase = retiredCount;
    endtask

    // Drains the pipeline, then reports the test
    task automatic finishTest();
        repeat (PIPE_DEPTH + 1) idleCycle();
        assert (expQ.size() == 0 && inFlight.size() == 0) else begin
            $display("%s: %0d expected retires never left the pipeline", testName, expQ.size());
            errorCount++;
        end
        expQ.delete();
        testsDone++;
        $display("%s: %0d retired, %0d errors", testName, retiredCount - testRetireBase,
                 errorCount - testErrorBase);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    task automatic runBusyTest();
        startTest("busyFlag");
        @(negedge clk);
        checkValue("retireValid after reset", 32'd0, retireValid);
        checkValue("pipelineBusy after reset", 32'd0, pipelineBusy);
        stepCycle(1'b1, encodeInstr(4'd0, 4'd1, 4'd0, 4'd0, 1'b1, 15'd77), 1'b0);
        @(negedge clk);
        checkValue("busy in strobe cycle", 32'd0, pipelineBusy);
        for (int k = 1; k <= PIPE_DEPTH + 1; k++) begin
            idleCycle();
            @(negedge clk);
            checkValue($sformatf("busy %0d after strobe", k), (k <= PIPE_DEPTH), pipelineBusy);
        end
        for (int k = 0; k < 3; k++) begin
            stepCycle(1'b1, encodeInstr(4'd0, regIdxT'(k + 2), 4'd1, 4'd0, 1'b1, immT'(k + 1)),
                      1'b0);
        end
        stepCycle(1'b0, '0, 1'b1);              // Oldest of the three sits in execute
        @(negedge clk);
        checkValue("busy in flush cycle", 32'd1, pipelineBusy);
        idleCycle();
        @(negedge clk);
        checkValue("busy after flush", 32'd0, pipelineBusy);
        finishTest();
    endtask

    task automatic runRandomTest();
        logic useImm;
        startTest("randomOps");
        for (int i = 0; i < RAND_STROBES; i++) begin
            useImm = (i < 16) ? (i >= 8) : (randomBits(1) != 0);   // Every op both ways
            stepCycle(1'b1, encodeInstr(4'(i % 8), regIdxT'(1 + randomBits(4) % 15),
                                        regIdxT'(randomBits(4)), regIdxT'(randomBits(4)),
                                        useImm, immT'(randomBits(IMM_W))), 1'b0);
            if (i < RAND_STROBES - 1) begin
                repeat (randomBits(1)) idleCycle();
            end
        end
        finishTest();
    endtask

    // Consumer i reads what instruction i - d wrote
    task automatic runChainTest();
        regIdxT rd;
        startTest("dependencyChains");
        for (int d = 1; d <= 4; d++) begin
            for (int i = 0; i < CHAIN_LEN; i++) begin
                rd = regIdxT'(1 + (i % d));
                stepCycle(1'b1, encodeInstr(4'(randomBits(3)), rd, rd, regIdxT'(randomBits(4)),
                                            randomBits(1) != 0, immT'(randomBits(IMM_W))), 1'b0);
            end
        end
        finishTest();
    endtask

    task automatic runZeroTest();
        regIdxT r;
        startTest("zeroRegAndIllegal");
        for (int g = 0; g < ZERO_GROUPS; g++) begin
            r = regIdxT'(1 + g);
            stepCycle(1'b1, encodeInstr(4'd0, r, 4'd0, 4'd0, 1'b1, immT'(randomBits(IMM_W))),
                      1'b0);                    // Seed r
            stepCycle(1'b1, encodeInstr(4'd0, 4'd0, r, 4'd0, 1'b1, immT'(randomBits(IMM_W))),
                      1'b0);                    // Write to r0
            stepCycle(1'b1, encodeInstr(4'(8 + randomBits(3)), r, r, 4'd0, 1'b0,
                                        immT'(randomBits(IMM_W))), 1'b0);
            stepCycle(1'b1, encodeInstr(4'd4, regIdxT'(9 + g), 4'd0, r, 1'b0, '0), 1'b0);
            stepCycle(1'b1, encodeInstr(4'd3, regIdxT'(5 + g), r, 4'd0, 1'b0, '0), 1'b0);
        end
        finishTest();
    endtask

    // Two flushes inside one burst
    task automatic runFlushTest();
        startTest("flushBurst");
        for (int i = 0; i < FLUSH_STROBES; i++) begin
            stepCycle(1'b1, encodeInstr(4'(randomBits(3)), regIdxT'(1 + i % 8),
                                        regIdxT'(1 + (i + 3) % 8), regIdxT'(1 + (i + 5) % 8),
                                        randomBits(1) != 0, immT'(randomBits(IMM_W))),
                      (i == 9) || (i == 16));
        end
        finishTest();
    endtask

    ////////////////////////////////////////////////////////////
    // Retire compare, sampled away from the clock edge
    always @(negedge clk) begin : compareRetire
        expectT want;
        if (rstN && retireValid) begin
            retiredCount++;
            assert (expQ.size() > 0) else begin
                $display("%s: instruction at pc %h retired but none was expected",
                         testName, retirePc);
                errorCount++;
            end
            if (expQ.size() > 0) begin
                want = expQ.pop_front();
                checkValue("pc", want.pc, retirePc);
                checkValue("rd", want.rd, retireRd);
                checkValue("data", want.data, retireData);
                checkValue("illegal", want.illegal, retireIllegal);
                checkValue("retire cycle", want.retireCycle, cycle);
            end
        end
    end

    // Watchdog
    initial begin : watchdog
        int ticks;
        ticks = 0;
        while (ticks < TIMEOUT_CYCLES) begin
            @(posedge clk);
            ticks++;
        end
        $display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin : mainSequence
        rstN         = 1'b0;
        exFlush      = 1'b0;
        instrValid   = 1'b0;
        instrWord    = '0;
        instrPc      = '0;
        cycle        = 0;
        errorCount   = 0;
        retiredCount = 0;
        testsDone    = 0;
        testName     = "reset";
        nextPc       = 32'h0000_1000;
        clearModel();
        repeat (RESET_CYCLES) idleCycle();
        rstN <= 1'b1;
        runBusyTest();
        runRandomTest();
        runChainTest();
        runZeroTest();
        runFlushTest();
        $display("tests %0d, instructions retired %0d, errors %0d",
                 testsDone, retiredCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verif
logic/backendPkg.sv
logic/stageIfs.sv
logic/decodeStage.sv
logic/operandStage.sv
logic/executeStage.sv
logic/retireStage.sv
logic/backendTop.sv
verif/backendTb.sv

// ==== Bender.yml ====
package:
  name: backend

sources:
  - logic/backendPkg.sv
  - logic/stageIfs.sv
  - logic/decodeStage.sv
  - logic/operandStage.sv
  - logic/executeStage.sv
  - logic/retireStage.sv
  - logic/backendTop.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/backendTb.sv
